// File: Bender.yml
package:
  name: square_chan

sources:
  - files:
      - verilog/apu_reg_pkg.sv
      - verilog/sq_chan_pkg.sv
      - verilog/sq_reg_decode.sv
      - verilog/sq_timer_duty.sv
      - verilog/sq_sweep_unit.sv
      - verilog/sq_envelope_length.sv
      - verilog/sq_output_stage.sv
      - verilog/square_chan.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/square_chan_assert.sv
      - test/square_chan_tb.sv

// File: filelist.f
verilog/apu_reg_pkg.sv
verilog/sq_chan_pkg.sv
verilog/sq_reg_decode.sv
verilog/sq_timer_duty.sv
verilog/sq_sweep_unit.sv
verilog/sq_envelope_length.sv
verilog/sq_output_stage.sv
verilog/square_chan.sv
test/tb_clock_gen.sv
test/square_chan_assert.sv
test/square_chan_tb.sv

// File: test/square_chan_assert.sv
// Concurrent checks on sample gating and strobes during reset
`timescale 1ns/1ps
`default_nettype none

module square_chan_assert (
	input wire       aclk,
	input wire       reset,
	input wire [3:0] sample,
	input wire       length_active,
	input wire       sweep_mute,
	input wire       period_write,
	input wire       restart,
	input wire       sweep_write
);

	int failures = 0;

	length_gate_a: assert property (@(posedge aclk) disable iff (reset)
		!length_active |=> sample == 4'd0)
		else begin
			$error("sample nonzero after the length counter expired");
			failures++;
		end

	mute_gate_a: assert property (@(posedge aclk) disable iff (reset)
		sweep_mute |=> sample == 4'd0)
		else begin
			$error("sample nonzero while the sweep mutes the channel");
			failures++;
		end

	// Strobes are registered, so they clear one edge into reset
	reset_strobes_a: assert property (@(posedge aclk)
		reset |=> !(period_write || restart || sweep_write))
		else begin
			$error("strobe high during reset");
			failures++;
		end

endmodule

`default_nettype wire

// File: test/square_chan_tb.sv
// Square channel testbench: case table, window measurements, compare tasks
`timescale 1ns/1ps
`default_nettype none

module square_chan_tb;

	import apu_reg_pkg::*;

	localparam logic [2:0] K_DUTY   = 3'd0;
	localparam logic [2:0] K_LENGTH = 3'd1;
	localparam logic [2:0] K_ENV    = 3'd2;
	localparam logic [2:0] K_SWEEP  = 3'd3;
	localparam logic [2:0] K_MUTE   = 3'd4;
	localparam int TIMEOUT   = 20000;
	localparam int SETTLE    = 2100;   // Longer than any old timer count
	localparam int NUM_CASES = 11;

	typedef struct packed {
		logic [2:0]  kind;
		logic [7:0]  ctrl;          // duty, halt, const_vol, volume
		logic [7:0]  sweep;         // enable, period, negate, shift
		logic [10:0] period;
		logic [4:0]  length_index;
		logic [3:0]  count;         // Envelope decay steps
		logic [11:0] expected;      // High steps, length load or swept period
	} case_t;

	localparam case_t CASES [NUM_CASES] = '{
		'{K_DUTY, {2'd0, 2'b11, 4'd10}, 8'h00, 11'd8, 5'd0, 4'd0, 12'd1},
		'{K_DUTY, {2'd1, 2'b11, 4'd7}, 8'h00, 11'd13, 5'd0, 4'd0, 12'd2},
		'{K_DUTY, {2'd2, 2'b11, 4'd15}, 8'h00, 11'd8, 5'd0, 4'd0, 12'd4},
		'{K_DUTY, {2'd3, 2'b11, 4'd3}, 8'h00, 11'd10, 5'd0, 4'd0, 12'd6},
		'{K_LENGTH, {2'd2, 2'b01, 4'd9}, 8'h00, 11'd8, 5'd5, 4'd0, 12'd4},
		'{K_ENV, {2'd2, 2'b00, 4'd1}, 8'h00, 11'd8, 5'd0, 4'd3, 12'd0},
		'{K_ENV, {2'd2, 2'b00, 4'd2}, 8'h00, 11'd9, 5'd0, 4'd2, 12'd0},
		'{K_SWEEP, {2'd2, 2'b11, 4'd12}, {1'b1, 3'd0, 1'b0, 3'd2}, 11'd256, 5'd0, 4'd0,
			12'(256 + (256 >> 2))},
		'{K_SWEEP, {2'd2, 2'b11, 4'd12}, {1'b1, 3'd0, 1'b1, 3'd2}, 11'd256, 5'd0, 4'd0,
			12'(256 - (256 >> 2) - 1)},
		'{K_MUTE, {2'd2, 2'b11, 4'd8}, 8'h00, 11'd5, 5'd0, 4'd0, 12'd0},
		'{K_MUTE, {2'd2, 2'b11, 4'd8}, {1'b0, 3'd0, 1'b0, 3'd1}, 11'd1536, 5'd0, 4'd0, 12'd0}
	};

	logic       aclk;
	logic       reset;
	reg_write_t wr;
	logic       quarter_frame;
	logic       half_frame;
	logic       enable;
	logic [3:0] sample;
	logic       length_active;

	tb_clock_gen clock_inst (.aclk(aclk), .reset(reset));

	square_chan square_chan_inst (.aclk(aclk), .reset(reset), .wr(wr),
		.quarter_frame(quarter_frame), .half_frame(half_frame), .enable(enable),
		.sample(sample), .length_active(length_active));

	bind square_chan square_chan_assert assert_inst (.aclk(aclk), .reset(reset),
		.sample(sample), .length_active(length_active), .sweep_mute(sweep_mute),
		.period_write(period_write), .restart(restart), .sweep_write(sweep_write));

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	always @(posedge aclk) begin
		if (square_chan_inst.assert_inst.failures != 0)
			stop_run("A concurrent assertion on the DUT failed");
	end

	task automatic check_sample(input logic [3:0] got, input logic [3:0] exp, input string what);
		if (got !== exp)
			stop_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			stop_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic check_period(input logic [10:0] got, input logic [10:0] exp,
		input string what);
		if (got !== exp)
			stop_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic write_reg(input logic [1:0] waddr, input logic [7:0] wdata);
		@(posedge aclk);
		wr <= '{valid: 1'b1, addr: waddr, data: wdata};
		@(posedge aclk);
		wr <= '0;
	endtask

	task automatic pulse_frame(input logic quarter);
		@(posedge aclk);
		if (quarter)
			quarter_frame <= 1'b1;
		else
			half_frame <= 1'b1;
		@(posedge aclk);
		quarter_frame <= 1'b0;
		half_frame    <= 1'b0;
		@(posedge aclk);   // Update has landed
	endtask

	// Count samples equal to level, other nonzero samples, and the peak
	task automatic scan_window(input logic [3:0] level, input int cycles, output int hits,
		output int others, output logic [3:0] peak);
		hits   = 0;
		others = 0;
		peak   = 4'd0;
		repeat (cycles) begin
			@(posedge aclk);
			if (sample == level)
				hits++;
			else if (sample != 4'd0)
				others++;
			if (sample > peak)
				peak = sample;
		end
	endtask

	task automatic wait_level(input logic high);
		int waited;
		waited = 0;
		@(posedge aclk);
		while ((sample != 4'd0) != high) begin
			if (waited == TIMEOUT)
				stop_run("Timeout: sample never changed level");
			waited++;
			@(posedge aclk);
		end
	endtask

	// Length of one high run, 4 * (period + 1) at 50 % duty
	task automatic measure_run(output int run);
		wait_level(1'b0);
		wait_level(1'b1);
		run = 0;
		while (sample != 4'd0) begin
			if (run == TIMEOUT)
				stop_run("Timeout: sample stuck high");
			run++;
			@(posedge aclk);
		end
	endtask

	task automatic configure(input case_t c);
		write_reg(REG_CTRL, c.ctrl);
		write_reg(REG_SWEEP, c.sweep);
		write_reg(REG_TIMER_LO, c.period[7:0]);
		write_reg(REG_TIMER_HI, {c.length_index, c.period[10:8]});
		repeat (SETTLE) @(posedge aclk);
	endtask

	initial begin
		case_t      c;
		int         hits;
		int         others;
		int         run;
		int         window;
		int         waited;
		logic [3:0] peak;
		wr            = '0;
		quarter_frame = 1'b0;
		half_frame    = 1'b0;
		enable        = 1'b1;
		waited        = 0;
		do begin
			if (waited == TIMEOUT)
				stop_run("Timeout: reset never released");
			waited++;
			@(posedge aclk);
		end while (reset !== 1'b0);
		repeat (16) begin
			@(posedge aclk);
			check_sample(sample, 4'd0, "sample after reset");
			check_count(int'(length_active), 0, "length_active after reset");
		end
		for (int i = 0; i < NUM_CASES; i++) begin
			c = CASES[i];
			configure(c);
			window = 8 * (int'(c.period) + 1);   // One duty cycle
			case (c.kind)
				K_DUTY: begin
					scan_window(c.ctrl[3:0], window * 4, hits, others, peak);
					check_count(hits, int'(c.expected) * (int'(c.period) + 1) * 4, "high cycles");
					check_count(others, 0, "samples of another value");
				end
				K_LENGTH: begin
					for (int n = 1; n <= int'(c.expected); n++) begin
						pulse_frame(1'b0);
						check_count(int'(length_active), int'(n < int'(c.expected)), "length_active");
					end
					scan_window(c.ctrl[3:0], window, hits, others, peak);
					check_sample(peak, 4'd0, "peak after length expiry");
					write_reg(REG_TIMER_HI, {c.length_index, c.period[10:8]});
					repeat (2) @(posedge aclk);
					check_count(int'(length_active), 1, "length_active after reload");
					enable <= 1'b0;
					repeat (2) @(posedge aclk);
					check_count(int'(length_active), 0, "length_active with enable low");
					enable <= 1'b1;
				end
				K_ENV: begin
					pulse_frame(1'b1);
					scan_window(4'd15, window, hits, others, peak);
					check_sample(peak, 4'd15, "envelope peak after start");
					repeat ((int'(c.ctrl[3:0]) + 1) * int'(c.count)) pulse_frame(1'b1);
					scan_window(4'd15, window, hits, others, peak);
					check_sample(peak, 4'(15 - int'(c.count)), "envelope peak after decay");
				end
				K_SWEEP: begin
					measure_run(run);
					check_period(11'(run / 4 - 1), c.period, "period before sweep");
					pulse_frame(1'b0);
					measure_run(run);
					measure_run(run);      // First run may straddle the old period
					check_period(11'(run / 4 - 1), c.expected[10:0], "period after sweep");
				end
				default: begin
					scan_window(c.ctrl[3:0], window, hits, others, peak);
					check_sample(peak, 4'd0, "peak of a muted channel");
				end
			endcase
		end
		repeat (2) @(posedge aclk);
		if (square_chan_inst.assert_inst.failures != 0) begin
			stop_run("A concurrent assertion on the DUT failed");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
// Testbench clock (8 ns period) and synchronous reset for 8 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic aclk,
	output logic reset
);

	initial begin
		aclk = 1'b0;
		forever #4 aclk = ~aclk;
	end

	initial begin
		reset = 1'b1;
		repeat (8) @(posedge aclk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: verilog/apu_reg_pkg.sv
// APU register map, CPU write bus and the decoded views of a register data byte
`default_nettype none

package apu_reg_pkg;

	localparam int REG_ADDR_W = 2;

	localparam logic [REG_ADDR_W-1:0] REG_CTRL     = 2'd0;
	localparam logic [REG_ADDR_W-1:0] REG_SWEEP    = 2'd1;
	localparam logic [REG_ADDR_W-1:0] REG_TIMER_LO = 2'd2;
	localparam logic [REG_ADDR_W-1:0] REG_TIMER_HI = 2'd3;

	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] addr;
		logic [7:0]            data;
	} reg_write_t;

	typedef struct packed {
		logic [1:0] duty;
		logic       halt;      // Also envelope loop
		logic       const_vol;
		logic [3:0] volume;    // Volume or envelope divider
	} ctrl_view_t;

	typedef struct packed {
		logic       enable;
		logic [2:0] period;
		logic       negate;
		logic [2:0] shift;
	} sweep_view_t;

	typedef struct packed {
		logic [4:0] length_index;
		logic [2:0] period_hi;
	} timer_hi_view_t;

	typedef union packed {
		ctrl_view_t     ctrl;
		sweep_view_t    sweep;
		logic [7:0]     timer_lo;
		timer_hi_view_t timer_hi;
	} reg_data_u;

endpackage

`default_nettype wire

// File: verilog/sq_chan_pkg.sv
// Square channel widths, duty patterns, length counter table, channel configuration
`default_nettype none

package sq_chan_pkg;

	localparam int PERIOD_W   = 11;
	localparam int VOL_W      = 4;
	localparam int DUTY_STEPS = 8;
	localparam int MIN_PERIOD = 8;

	// Bit n of a pattern is the level at duty step n
	localparam logic [0:3][DUTY_STEPS-1:0] DUTY_TABLE = '{
		8'b0100_0000,  // 12.5 %
		8'b0110_0000,  // 25 %
		8'b0111_1000,  // 50 %
		8'b1001_1111   // 75 %, inverted 25 %
	};

	localparam logic [0:31][7:0] LENGTH_TABLE = '{
		8'd10,  8'd254, 8'd20,  8'd2,   8'd40,  8'd4,   8'd80,  8'd6,
		8'd160, 8'd8,   8'd60,  8'd10,  8'd14,  8'd12,  8'd26,  8'd14,
		8'd12,  8'd16,  8'd24,  8'd18,  8'd48,  8'd20,  8'd96,  8'd22,
		8'd192, 8'd24,  8'd72,  8'd26,  8'd16,  8'd28,  8'd32,  8'd30
	};

	typedef struct packed {
		logic [1:0]          duty;
		logic                halt;
		logic                const_vol;
		logic [VOL_W-1:0]    volume;
		logic                sweep_en;
		logic [2:0]          sweep_period;
		logic                sweep_negate;
		logic [2:0]          sweep_shift;
		logic [PERIOD_W-1:0] period;       // As written by the CPU
		logic [4:0]          length_index;
	} sq_cfg_t;

endpackage

`default_nettype wire

// File: verilog/sq_envelope_length.sv
// Envelope divider and decay level, length counter
`timescale 1ns/1ps
`default_nettype none

module sq_envelope_length (
	input  wire                          aclk,
	input  wire                          reset,
	input  wire sq_chan_pkg::sq_cfg_t    cfg,
	input  wire                          restart,
	input  wire                          quarter_frame,
	input  wire                          half_frame,
	input  wire                          enable,
	output logic [sq_chan_pkg::VOL_W-1:0] volume,
	output logic                         length_active
);

	import sq_chan_pkg::*;

	logic             start_flag;
	logic [VOL_W-1:0] env_div;
	logic [VOL_W-1:0] decay;
	logic [7:0]       length_count;

	always_ff @(posedge aclk) begin
		if (reset) begin
			start_flag <= 1'b0;
			env_div    <= '0;
			decay      <= '0;
		end else begin
			if (quarter_frame) begin
				if (start_flag) begin
					start_flag <= 1'b0;
					decay      <= '1;
					env_div    <= cfg.volume;
				end else if (env_div == '0) begin
					env_div <= cfg.volume;
					if (decay != '0) begin
						decay <= decay - 1'b1;
					end else if (cfg.halt) begin
						decay <= '1;  // Loop
					end
				end else begin
					env_div <= env_div - 1'b1;
				end
			end
			if (restart) begin
				start_flag <= 1'b1;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (reset || !enable) begin
			length_count <= '0;
		end else if (restart) begin
			length_count <= LENGTH_TABLE[cfg.length_index];
		end else if (half_frame && length_count != '0 && !cfg.halt) begin
			length_count <= length_count - 1'b1;
		end
	end

	assign length_active = length_count != '0;
	assign volume        = cfg.const_vol ? cfg.volume : decay;

endmodule

`default_nettype wire

// File: verilog/sq_output_stage.sv
// Registered sample output with duty, mute and length gating
`timescale 1ns/1ps
`default_nettype none

module sq_output_stage (
	input  wire                          aclk,
	input  wire                          reset,
	input  wire                          duty_level,
	input  wire                          sweep_mute,
	input  wire                          length_active,
	input  wire [sq_chan_pkg::VOL_W-1:0] volume,
	output logic [sq_chan_pkg::VOL_W-1:0] sample
);

	always_ff @(posedge aclk) begin
		if (reset) begin
			sample <= '0;
		end else if (duty_level && length_active && !sweep_mute) begin
			sample <= volume;
		end else begin
			sample <= '0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/sq_reg_decode.sv
// Register decode: channel register file, configuration and restart strobes
`timescale 1ns/1ps
`default_nettype none

module sq_reg_decode (
	input  wire                     aclk,
	input  wire                     reset,
	input  wire apu_reg_pkg::reg_write_t wr,
	output sq_chan_pkg::sq_cfg_t    cfg,
	output logic                    period_write,
	output logic                    restart,
	output logic                    sweep_write
);

	import apu_reg_pkg::*;

	reg_data_u data;

	assign data = wr.data;

	always_ff @(posedge aclk) begin
		if (reset) begin
			cfg          <= '0;
			period_write <= 1'b0;
			restart      <= 1'b0;
			sweep_write  <= 1'b0;
		end else begin
			period_write <= wr.valid && (wr.addr == REG_TIMER_LO || wr.addr == REG_TIMER_HI);
			restart      <= wr.valid && (wr.addr == REG_TIMER_HI);
			sweep_write  <= wr.valid && (wr.addr == REG_SWEEP);
			if (wr.valid) begin
				case (wr.addr)
					REG_CTRL: begin
						cfg.duty      <= data.ctrl.duty;
						cfg.halt      <= data.ctrl.halt;
						cfg.const_vol <= data.ctrl.const_vol;
						cfg.volume    <= data.ctrl.volume;
					end
					REG_SWEEP: begin
						cfg.sweep_en     <= data.sweep.enable;
						cfg.sweep_period <= data.sweep.period;
						cfg.sweep_negate <= data.sweep.negate;
						cfg.sweep_shift  <= data.sweep.shift;
					end
					REG_TIMER_LO: cfg.period[7:0] <= data.timer_lo;
					default: begin
						cfg.period[10:8]  <= data.timer_hi.period_hi;
						cfg.length_index  <= data.timer_hi.length_index;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/sq_sweep_unit.sv
// Sweep unit: divider, shifter and adder for the target period, mute detection,
// and the current period register
`timescale 1ns/1ps
`default_nettype none

module sq_sweep_unit #(
	parameter bit SWEEP_ONES_COMPLEMENT = 1'b1
) (
	input  wire                             aclk,
	input  wire                             reset,
	input  wire sq_chan_pkg::sq_cfg_t       cfg,
	input  wire                             period_write,
	input  wire                             sweep_write,
	input  wire                             half_frame,
	output logic [sq_chan_pkg::PERIOD_W-1:0] period,
	output logic                            sweep_mute
);

	import sq_chan_pkg::*;

	logic [PERIOD_W-1:0] shifted;
	logic [PERIOD_W-1:0] addend;
	logic                carry_in;
	logic [PERIOD_W:0]   target;
	logic [2:0]          divider;
	logic                sweep_apply;

	assign shifted = period >> cfg.sweep_shift;
	assign addend  = cfg.sweep_negate ? ~shifted : shifted;

	// Ones complement subtracts one extra
	assign carry_in = cfg.sweep_negate && !SWEEP_ONES_COMPLEMENT;
	assign target   = {1'b0, period} + {1'b0, addend} + {{PERIOD_W{1'b0}}, carry_in};

	// Carry out only counts as overflow when adding
	assign sweep_mute = (period < PERIOD_W'(MIN_PERIOD)) ||
		(!cfg.sweep_negate && target[PERIOD_W]);

	assign sweep_apply = half_frame && divider == 3'd0 && cfg.sweep_en &&
		cfg.sweep_shift != 3'd0 && !sweep_mute;

	always_ff @(posedge aclk) begin
		if (reset) begin
			divider <= 3'd0;
		end else if (sweep_write) begin
			divider <= cfg.sweep_period;
		end else if (half_frame) begin
			if (divider == 3'd0) begin
				divider <= cfg.sweep_period;
			end else begin
				divider <= divider - 1'b1;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			period <= '0;
		end else if (period_write) begin
			period <= cfg.period;
		end else if (sweep_apply) begin
			period <= target[PERIOD_W-1:0];
		end
	end

endmodule

`default_nettype wire

// File: verilog/sq_timer_duty.sv
// Period down-counter and 8-step duty sequencer
`timescale 1ns/1ps
`default_nettype none

module sq_timer_duty (
	input  wire                             aclk,
	input  wire                             reset,
	input  wire [sq_chan_pkg::PERIOD_W-1:0] period,
	input  wire                             restart,
	input  wire [1:0]                       duty,
	output logic                            duty_level
);

	import sq_chan_pkg::*;

	localparam int STEP_W = $clog2(DUTY_STEPS);

	logic [PERIOD_W-1:0] count;
	logic [STEP_W-1:0]   step;

	always_ff @(posedge aclk) begin
		if (reset) begin
			count <= '0;
		end else if (count == '0) begin
			count <= period;      // Reload, one step per period + 1 clocks
		end else begin
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			step       <= '0;
			duty_level <= 1'b0;
		end else begin
			if (restart) begin
				step <= '0;
			end else if (count == '0) begin
				step <= step + 1'b1;
			end
			duty_level <= DUTY_TABLE[duty][step];
		end
	end

endmodule

`default_nettype wire

// File: verilog/square_chan.sv
// Square channel top: decode, timer, sweep, envelope and output stage
`timescale 1ns/1ps
`default_nettype none

module square_chan #(
	parameter bit SWEEP_ONES_COMPLEMENT = 1'b1  // 0 for the second channel variant
) (
	input  wire                          aclk,
	input  wire                          reset,
	input  wire apu_reg_pkg::reg_write_t wr,
	input  wire                          quarter_frame,
	input  wire                          half_frame,
	input  wire                          enable,
	output logic [sq_chan_pkg::VOL_W-1:0] sample,
	output logic                         length_active
);

	import sq_chan_pkg::*;

	sq_cfg_t             cfg;
	logic                period_write;
	logic                restart;
	logic                sweep_write;
	logic [PERIOD_W-1:0] period;
	logic                sweep_mute;
	logic                duty_level;
	logic [VOL_W-1:0]    volume;

	sq_reg_decode decode_inst (.aclk(aclk), .reset(reset), .wr(wr), .cfg(cfg),
		.period_write(period_write), .restart(restart), .sweep_write(sweep_write));

	sq_timer_duty timer_inst (.aclk(aclk), .reset(reset), .period(period), .restart(restart),
		.duty(cfg.duty), .duty_level(duty_level));

	sq_sweep_unit #(.SWEEP_ONES_COMPLEMENT(SWEEP_ONES_COMPLEMENT)) sweep_inst (.aclk(aclk),
		.reset(reset), .cfg(cfg), .period_write(period_write), .sweep_write(sweep_write),
		.half_frame(half_frame), .period(period), .sweep_mute(sweep_mute));

	sq_envelope_length env_inst (.aclk(aclk), .reset(reset), .cfg(cfg), .restart(restart),
		.quarter_frame(quarter_frame), .half_frame(half_frame), .enable(enable),
		.volume(volume), .length_active(length_active));

	sq_output_stage out_inst (.aclk(aclk), .reset(reset), .duty_level(duty_level),
		.sweep_mute(sweep_mute), .length_active(length_active), .volume(volume),
		.sample(sample));

endmodule

`default_nettype wire
